// ==== compile.f ====
hw/vfxp_pkg.sv
hw/vsaaddsub.sv
hw/vfxp_exec.sv
hw/vfxp_apb_regs.sv
hw/vfxp_top.sv
test/vfxp_props.sv
test/vfxp_tb.sv

// ==== hw/vfxp_apb_regs.sv ====
// APB register block for operands, control, rounding mode, flags and result
`timescale 1ns/1ps
`default_nettype none

module vfxp_apb_regs (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [vfxp_pkg::APB_AW-1:0] paddr_i,
    input  logic [31:0]                 pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output vfxp_pkg::fxp_req_t          req_o,
    output logic                        issue_o,        // One cycle after a CTRL write
    output logic                        vxsat_clr_o,
    input  vfxp_pkg::fxp_rsp_t          rsp_i,
    input  logic                        rsp_valid_i,
    input  logic                        vxsat_i
);
    import vfxp_pkg::*;

    logic        access;        // APB access cycle
    logic        addr_hit;
    logic        addr_ro;
    logic        wr_ok;
    logic        ctrl_wr;
    logic [31:0] rdata;

    vlanes_u     vs1_q;
    vlanes_u     vs2_q;
    vlanes_u     vd_q;
    fxp_op_t     op_q;
    sew_t        sew_q;
    vxrm_t       vxrm_q;
    logic        issue_q;
    logic        done_q;

    assign access = psel_i & penable_i;

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rdata    = 32'd0;
        case (paddr_i)
            REG_VS1_LO: rdata = vs1_q.w[0];
            REG_VS1_HI: rdata = vs1_q.w[1];
            REG_VS2_LO: rdata = vs2_q.w[0];
            REG_VS2_HI: rdata = vs2_q.w[1];
            REG_CTRL:   rdata = {26'd0, sew_q, 1'b0, op_q};
            REG_VXRM:   rdata = {30'd0, vxrm_q};
            REG_VXSAT:  rdata = {31'd0, vxsat_i};
            REG_STATUS: begin
                rdata   = {31'd0, done_q};
                addr_ro = 1'b1;
            end
            REG_VD_LO: begin
                rdata   = vd_q.w[0];
                addr_ro = 1'b1;
            end
            REG_VD_HI: begin
                rdata   = vd_q.w[1];
                addr_ro = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    // Unmapped addresses and writes to read-only registers fail and change nothing
    assign pslverr_o   = access & (~addr_hit | (pwrite_i & addr_ro));
    assign wr_ok       = access & pwrite_i & ~pslverr_o;
    assign ctrl_wr     = wr_ok & (paddr_i == REG_CTRL);
    assign vxsat_clr_o = wr_ok & (paddr_i == REG_VXSAT);
    assign prdata_o    = (access & ~pwrite_i) ? rdata : 32'd0;
    assign pready_o    = 1'b1;          // No wait states

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vs1_q   <= '0;
            vs2_q   <= '0;
            op_q    <= VSADDU;
            sew_q   <= SEW_8;
            vxrm_q  <= RNU_V;
            issue_q <= 1'b0;
        end else begin
            issue_q <= ctrl_wr;
            if (wr_ok) begin
                case (paddr_i)
                    REG_VS1_LO: vs1_q.w[0] <= pwdata_i;
                    REG_VS1_HI: vs1_q.w[1] <= pwdata_i;
                    REG_VS2_LO: vs2_q.w[0] <= pwdata_i;
                    REG_VS2_HI: vs2_q.w[1] <= pwdata_i;
                    REG_CTRL: begin
                        op_q  <= fxp_op_t'(pwdata_i[2:0]);
                        sew_q <= sew_t'(pwdata_i[5:4]);
                    end
                    REG_VXRM:   vxrm_q <= vxrm_t'(pwdata_i[1:0]);
                    default: ;
                endcase
            end
        end
    end

    // Result and done, a new CTRL write drops done even if an old result lands
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vd_q   <= '0;
            done_q <= 1'b0;
        end else begin
            if (rsp_valid_i) begin
                vd_q <= rsp_i.vd;
            end
            if (ctrl_wr) begin
                done_q <= 1'b0;
            end else if (rsp_valid_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign issue_o    = issue_q;
    assign req_o.op   = op_q;
    assign req_o.sew  = sew_q;
    assign req_o.vxrm = vxrm_q;
    assign req_o.vs1  = vs1_q;
    assign req_o.vs2  = vs2_q;

endmodule

`default_nettype wire

// ==== hw/vfxp_exec.sv ====
// Execution stage that registers the fixed-point result and keeps the sticky vxsat bit
`timescale 1ns/1ps
`default_nettype none

module vfxp_exec (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               issue_i,         // Start of one operation
    input  vfxp_pkg::fxp_req_t req_i,
    input  logic               vxsat_clr_i,     // Software clear of vxsat
    output vfxp_pkg::fxp_rsp_t rsp_o,
    output logic               rsp_valid_o,
    output logic               vxsat_o
);
    import vfxp_pkg::*;

    vlanes_u vd_c;
    logic    sat_c;

    vsaaddsub u_vsaaddsub (
        .op_i       (req_i.op),
        .sew_i      (req_i.sew),
        .vxrm_i     (req_i.vxrm),
        .data_vs1_i (req_i.vs1),
        .data_vs2_i (req_i.vs2),
        .data_vd_o  (vd_c),
        .sat_ovf_o  (sat_c)
    );

    // Result register, loaded once per issue
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            rsp_o.vd  <= vd_c;
            rsp_o.sat <= sat_c;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
            vxsat_o     <= 1'b0;
        end else begin
            rsp_valid_o <= issue_i;

            // Sticky flag, a new saturation beats a clear in the same cycle
            if (issue_i && sat_c) begin
                vxsat_o <= 1'b1;
            end else if (vxsat_clr_i) begin
                vxsat_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/vfxp_pkg.sv ====
// Shared types and APB register map of the vector fixed-point unit
`default_nettype none

package vfxp_pkg;

    localparam int unsigned APB_AW = 8;     // APB address width

    // Register offsets, one 32-bit word each
    localparam logic [APB_AW-1:0] REG_VS1_LO = 8'h00;
    localparam logic [APB_AW-1:0] REG_VS1_HI = 8'h04;
    localparam logic [APB_AW-1:0] REG_VS2_LO = 8'h08;
    localparam logic [APB_AW-1:0] REG_VS2_HI = 8'h0C;
    localparam logic [APB_AW-1:0] REG_CTRL   = 8'h10;   // op in 2:0, sew in 5:4
    localparam logic [APB_AW-1:0] REG_VXRM   = 8'h14;
    localparam logic [APB_AW-1:0] REG_VXSAT  = 8'h18;   // Any write clears
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h1C;   // Bit 0 is done
    localparam logic [APB_AW-1:0] REG_VD_LO  = 8'h20;
    localparam logic [APB_AW-1:0] REG_VD_HI  = 8'h24;

    // Fixed-point add/subtract operations
    typedef enum logic [2:0] {
        VSADDU = 3'd0,      // Saturating add, unsigned
        VSADD  = 3'd1,      // Saturating add, signed
        VSSUBU = 3'd2,      // Saturating subtract, unsigned
        VSSUB  = 3'd3,      // Saturating subtract, signed
        VAADDU = 3'd4,      // Averaging add, unsigned
        VAADD  = 3'd5,      // Averaging add, signed
        VASUBU = 3'd6,      // Averaging subtract, unsigned
        VASUB  = 3'd7       // Averaging subtract, signed
    } fxp_op_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // Rounding modes as encoded in the vxrm CSR
    typedef enum logic [1:0] {
        RNU_V = 2'd0,       // Round to nearest, ties up
        RNE_V = 2'd1,       // Round to nearest, ties to even
        RDN_V = 2'd2,       // Truncate
        ROD_V = 2'd3        // Round to odd
    } vxrm_t;

    // One 64-bit register slice seen as lanes of every element width
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } vlanes_u;

    typedef struct packed {
        fxp_op_t op;
        sew_t    sew;
        vxrm_t   vxrm;
        vlanes_u vs1;
        vlanes_u vs2;
    } fxp_req_t;

    typedef struct packed {
        vlanes_u vd;
        logic    sat;       // Some element of this result saturated
    } fxp_rsp_t;

endpackage

`default_nettype wire

// ==== hw/vfxp_top.sv ====
// Top level of the APB controlled vector fixed-point unit
`timescale 1ns/1ps
`default_nettype none

module vfxp_top (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [vfxp_pkg::APB_AW-1:0] paddr_i,
    input  logic [31:0]                 pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);
    import vfxp_pkg::*;

    fxp_req_t req;
    fxp_rsp_t rsp;
    logic     issue;
    logic     rsp_valid;
    logic     vxsat;
    logic     vxsat_clr;

    vfxp_apb_regs u_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .req_o       (req),
        .issue_o     (issue),
        .vxsat_clr_o (vxsat_clr),
        .rsp_i       (rsp),
        .rsp_valid_i (rsp_valid),
        .vxsat_i     (vxsat)
    );

    vfxp_exec u_exec (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_i     (issue),
        .req_i       (req),
        .vxsat_clr_i (vxsat_clr),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .vxsat_o     (vxsat)
    );

endmodule

`default_nettype wire

// ==== hw/vsaaddsub.sv ====
// Saturating and averaging add/subtract over every lane of one 64-bit word
`timescale 1ns/1ps
`default_nettype none

module vsaaddsub (
    input  vfxp_pkg::fxp_op_t op_i,         // Operation select
    input  vfxp_pkg::sew_t    sew_i,        // Element width
    input  vfxp_pkg::vxrm_t   vxrm_i,       // Fixed-point rounding mode
    input  vfxp_pkg::vlanes_u data_vs1_i,   // Source operand 1
    input  vfxp_pkg::vlanes_u data_vs2_i,   // Source operand 2
    output vfxp_pkg::vlanes_u data_vd_o,    // Result
    output logic              sat_ovf_o     // An element saturated
);
    import vfxp_pkg::*;

    logic       is_signed;
    logic       is_sub;
    logic       is_avg;
    logic [2:0] top_mask;       // Byte index bits that stay inside one element

    vlanes_u    opb;            // Second adder operand
    vlanes_u    sum_w;          // Byte adder results
    vlanes_u    sat_res;
    vlanes_u    avg_res;

    logic [7:0] cout;
    logic [7:0] ext;            // Bit d of the widened element sum
    logic [7:0] ovf;            // Valid only at an element's top byte
    logic [7:0] last;           // Byte is the top of its element

    // Rounding increment after a shift right by one, v holds the two low sum bits
    function automatic logic rnd_inc(input vxrm_t mode, input logic [1:0] v);
        case (mode)
            RNU_V:   rnd_inc = v[0];
            RNE_V:   rnd_inc = v[0] & v[1];
            RDN_V:   rnd_inc = 1'b0;
            default: rnd_inc = v[0] & ~v[1];   // Jam the lost bit into the lsb
        endcase
    endfunction

    assign is_signed = op_i inside {VSADD, VSSUB, VAADD, VASUB};
    assign is_sub    = op_i inside {VSSUBU, VSSUB, VASUBU, VASUB};
    assign is_avg    = op_i inside {VAADDU, VAADD, VASUBU, VASUB};

    always_comb begin
        case (sew_i)
            SEW_8:   top_mask = 3'd0;
            SEW_16:  top_mask = 3'd1;
            SEW_32:  top_mask = 3'd3;
            default: top_mask = 3'd7;
        endcase
    end

    // vs2 - vs1 is computed as vs2 + ~vs1 + 1
    assign opb.d = is_sub ? ~data_vs1_i.d : data_vs1_i.d;

    // Byte-sliced adder
    // The carry runs on inside an element and restarts at each element's low byte
    always_comb begin : byte_adders
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if ((3'(i) & top_mask) == 3'd0) begin
                carry = is_sub;                 // Lowest byte of an element
            end
            {cout[i], sum_w.b[i]} = {1'b0, data_vs2_i.b[i]} + {1'b0, opb.b[i]}
                                  + {8'd0, carry};
            carry = cout[i];

            // Extend both operands by one bit to get the true top of the sum
            if (is_signed) begin
                ext[i] = data_vs2_i.b[i][7] ^ opb.b[i][7] ^ cout[i];
                ovf[i] = ext[i] ^ sum_w.b[i][7];
            end else begin
                ext[i] = is_sub ^ cout[i];      // Carry on add, borrow on subtract
                ovf[i] = ext[i];
            end
            last[i] = (3'(i) & top_mask) == top_mask;
        end
    end

    // Saturation, each byte follows the overflow of its element's top byte
    always_comb begin : saturate
        logic [2:0] top;
        logic [7:0] sat_byte;
        for (int i = 0; i < 8; i++) begin
            top = 3'(i) | top_mask;
            if (!is_signed) begin
                sat_byte = is_sub ? 8'h00 : 8'hFF;
            end else if (ext[top]) begin
                sat_byte = (3'(i) == top) ? 8'h80 : 8'h00;     // Most negative
            end else begin
                sat_byte = (3'(i) == top) ? 8'h7F : 8'hFF;     // Most positive
            end
            sat_res.b[i] = ovf[top] ? sat_byte : sum_w.b[i];
        end
    end

    // Averaging
    // The widened sum is shifted right by one, then rounded per element
    always_comb begin : average
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    avg_res.b[i] = {ext[i], sum_w.b[i][7:1]}
                                 + {7'd0, rnd_inc(vxrm_i, sum_w.b[i][1:0])};
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    avg_res.h[i] = {ext[2*i+1], sum_w.h[i][15:1]}
                                 + {15'd0, rnd_inc(vxrm_i, sum_w.h[i][1:0])};
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    avg_res.w[i] = {ext[4*i+3], sum_w.w[i][31:1]}
                                 + {31'd0, rnd_inc(vxrm_i, sum_w.w[i][1:0])};
                end
            end
            default: begin
                avg_res.d = {ext[7], sum_w.d[63:1]}
                          + {63'd0, rnd_inc(vxrm_i, sum_w.d[1:0])};
            end
        endcase
    end

    assign data_vd_o.d = is_avg ? avg_res.d : sat_res.d;

    // Averaging never saturates
    assign sat_ovf_o = ~is_avg & (|(ovf & last));

endmodule

`default_nettype wire

// ==== test/vfxp_props.sv ====
// Assertions on the APB handshake, the issue pulse and the done flag of the register block
`timescale 1ns/1ps
`default_nettype none

module vfxp_props (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic                        psel_i,
    input logic                        penable_i,
    input logic                        pwrite_i,
    input logic [vfxp_pkg::APB_AW-1:0] paddr_i,
    input logic                        pready_i,
    input logic                        pslverr_i,
    input logic                        issue_i,
    input logic                        rsp_valid_i,
    input logic                        done_i
);
    import vfxp_pkg::*;

    logic ctrl_done;        // CTRL write completing in this cycle

    assign ctrl_done = psel_i & penable_i & pwrite_i & ~pslverr_i & (paddr_i == REG_CTRL);

    a_pready: assert property (@(posedge clk_i) disable iff (reset_i) pready_i)
        else $error("pready_o went low");

    a_pslverr_access: assert property (@(posedge clk_i) disable iff (reset_i)
        pslverr_i |-> psel_i && penable_i)
        else $error("pslverr_o high outside an access cycle");

    a_issue_src: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_i |-> $past(ctrl_done))
        else $error("issue without a completed CTRL write");

    a_issue_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_i |=> !issue_i)
        else $error("issue longer than one cycle");

    a_done_rise: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(done_i) |-> $past(rsp_valid_i))
        else $error("done rose without rsp_valid in the cycle before");

endmodule

bind vfxp_apb_regs vfxp_props u_props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pready_i    (pready_o),
    .pslverr_i   (pslverr_o),
    .issue_i     (issue_o),
    .rsp_valid_i (rsp_valid_i),
    .done_i      (done_q)
);

`default_nettype wire

// ==== test/vfxp_tb.sv ====
// Testbench that drives the vector fixed-point unit over APB and checks it against a lane model
`timescale 1ns/1ps
`default_nettype none

module vfxp_tb;
    import vfxp_pkg::*;

    localparam int N_TESTS = 140;               // Operations plus directed checks
    localparam int TIMEOUT = N_TESTS * 20 + 200;

    logic              clk_i;
    logic              reset_i;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [31:0]       pwdata_i;
    logic [31:0]       prdata_o;
    logic              pready_o;
    logic              pslverr_o;

    logic [31:0] lfsr_q;
    logic        exp_vxsat;                     // Sticky flag as software expects it
    vxrm_t       cur_rm;                        // Rounding mode held in VXRM
    vlanes_u     last_vd;
    int          cycles = 0;

    vfxp_top u_dut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            stop_run($sformatf("Timeout after %0d cycles with tests still running", TIMEOUT));
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_vd(input string name, input vlanes_u got, input vlanes_u exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic check_rm(input string name, input vxrm_t got, input vxrm_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[62:0], lfsr_q[0]};           // One step per bit
        end
        return v;
    endfunction

    // Force some elements to an extreme so that lanes really saturate
    function automatic logic [63:0] add_extremes(input logic [63:0] v, input int w);
        logic [63:0] lm;
        logic [2:0]  sel;
        lm = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
        for (int e = 0; e < 64; e += w) begin
            sel = 3'(rand_bits(3));
            case (sel)
                3'd4: v = v | (lm << e);                                // All ones
                3'd5: v = v & ~(lm << e);
                3'd6: v = (v & ~(lm << e)) | ((lm >> 1) << e);          // Signed maximum
                3'd7: v = (v & ~(lm << e)) | ((lm ^ (lm >> 1)) << e);   // Signed minimum
                default: ;
            endcase
        end
        return v;
    endfunction

    // Expected result with each element computed as a wide integer and then clamped or rounded
    function automatic fxp_rsp_t fxp_model(input fxp_op_t op, input sew_t sew,
                                           input vxrm_t rm, input vlanes_u vs1,
                                           input vlanes_u vs2);
        fxp_rsp_t           res;
        int                 w;
        logic               sgn;
        logic               sub;
        logic               inc;
        logic [63:0]        lm;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic signed [65:0] a;
        logic signed [65:0] b;
        logic signed [65:0] r;
        logic signed [65:0] mx;
        logic signed [65:0] mn;
        w   = 8 << sew;
        sgn = op inside {VSADD, VSSUB, VAADD, VASUB};
        sub = op inside {VSSUBU, VSSUB, VASUBU, VASUB};
        lm  = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
        res = '0;
        for (int e = 0; e < 64; e += w) begin
            ua = (vs2.d >> e) & lm;
            ub = (vs1.d >> e) & lm;
            a  = $signed({2'b00, ua});
            b  = $signed({2'b00, ub});
            if (sgn && ua[w-1]) a = a - (66'sd1 <<< w);
            if (sgn && ub[w-1]) b = b - (66'sd1 <<< w);
            r  = sub ? a - b : a + b;
            mx = sgn ? (66'sd1 <<< (w - 1)) - 66'sd1 : (66'sd1 <<< w) - 66'sd1;
            mn = sgn ? -(66'sd1 <<< (w - 1)) : 66'sd0;
            if (op inside {VAADDU, VAADD, VASUBU, VASUB}) begin
                case (rm)
                    RNU_V:   inc = r[0];
                    RNE_V:   inc = r[0] & r[1];
                    RDN_V:   inc = 1'b0;
                    default: inc = r[0] & ~r[1];
                endcase
                r = r >>> 1;
                if (inc) r = r + 66'sd1;
            end else if (r > mx) begin
                r       = mx;
                res.sat = 1'b1;
            end else if (r < mn) begin
                r       = mn;
                res.sat = 1'b1;
            end
            res.vd.d = res.vd.d | ((r[63:0] & lm) << e);
        end
        return res;
    endfunction

    task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        psel_i    = 1'b1;                       // Setup cycle
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(posedge clk_i);
        #1 penable_i = 1'b1;
        #1 check_err("pslverr_o", pslverr_o, exp_err);
        check_flag("pready_o", pready_o, 1'b1);
        @(posedge clk_i);
        #1 psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                            input logic exp_err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(posedge clk_i);
        #1 penable_i = 1'b1;
        #1 data = prdata_o;                     // Stable in the access cycle
        check_err("pslverr_o", pslverr_o, exp_err);
        check_flag("pready_o", pready_o, 1'b1);
        @(posedge clk_i);
        #1 psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic set_rm(input vxrm_t rm);
        logic [31:0] rd;
        write_reg(REG_VXRM, {30'd0, rm}, 1'b0);
        read_reg(REG_VXRM, rd, 1'b0);
        check_rm("vxrm", vxrm_t'(rd[1:0]), rm);
        cur_rm = rm;
    endtask

    task automatic run_op(input fxp_op_t op, input sew_t sew, input vlanes_u vs1,
                          input vlanes_u vs2);
        fxp_rsp_t    exp;
        vlanes_u     got;
        logic [31:0] rd;
        exp = fxp_model(op, sew, cur_rm, vs1, vs2);
        write_reg(REG_VS1_LO, vs1.w[0], 1'b0);
        write_reg(REG_VS1_HI, vs1.w[1], 1'b0);
        write_reg(REG_VS2_LO, vs2.w[0], 1'b0);
        write_reg(REG_VS2_HI, vs2.w[1], 1'b0);
        write_reg(REG_CTRL, {26'd0, sew, 1'b0, op}, 1'b0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status.done", rd[0], 1'b0); // Cleared by the CTRL write
        while (!rd[0]) begin
            read_reg(REG_STATUS, rd, 1'b0);
        end
        read_reg(REG_VD_LO, got.w[0], 1'b0);
        read_reg(REG_VD_HI, got.w[1], 1'b0);
        check_vd("vd", got, exp.vd);
        exp_vxsat = exp_vxsat | exp.sat;
        read_reg(REG_VXSAT, rd, 1'b0);
        check_flag("vxsat", rd[0], exp_vxsat);
        last_vd = exp.vd;
    endtask

    initial begin
        logic [31:0] rd;
        vlanes_u     a;
        vlanes_u     b;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        reset_i   = 1'b1;
        lfsr_q    = 32'd25;
        exp_vxsat = 1'b0;
        cur_rm    = RNU_V;
        last_vd   = '0;
        repeat (3) @(posedge clk_i);
        #1 reset_i = 1'b0;

        // Reset values
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status.done", rd[0], 1'b0);
        read_reg(REG_VXRM, rd, 1'b0);
        check_rm("vxrm", vxrm_t'(rd[1:0]), RNU_V);
        read_reg(REG_VXSAT, rd, 1'b0);
        check_flag("vxsat", rd[0], 1'b0);

        // Saturating add and subtract at every width
        for (int rep = 0; rep < 4; rep++) begin
            for (int s = 0; s < 4; s++) begin
                for (int o = 0; o < 4; o++) begin
                    a.d = add_extremes(rand_bits(64), 8 << s);
                    b.d = add_extremes(rand_bits(64), 8 << s);
                    run_op(fxp_op_t'(3'(o)), sew_t'(2'(s)), a, b);
                end
            end
        end

        // Sticky flag holds through a clean result and clears on a write
        write_reg(REG_VXSAT, 32'd0, 1'b0);
        exp_vxsat = 1'b0;
        read_reg(REG_VXSAT, rd, 1'b0);
        check_flag("vxsat", rd[0], 1'b0);
        a.d = {8{8'h01}};
        b.d = '1;
        run_op(VSADDU, SEW_8, a, b);            // Every lane overflows
        a.d = '0;
        run_op(VSADDU, SEW_8, a, a);
        write_reg(REG_VXSAT, 32'd1, 1'b0);
        exp_vxsat = 1'b0;
        read_reg(REG_VXSAT, rd, 1'b0);
        check_flag("vxsat", rd[0], 1'b0);

        // Averaging under every rounding mode
        for (int m = 0; m < 4; m++) begin
            set_rm(vxrm_t'(2'(m)));
            for (int s = 0; s < 4; s++) begin
                for (int o = 4; o < 8; o++) begin
                    a.d = add_extremes(rand_bits(64), 8 << s);
                    b.d = add_extremes(rand_bits(64), 8 << s);
                    run_op(fxp_op_t'(3'(o)), sew_t'(2'(s)), a, b);
                end
            end
        end

        // Slave errors leave the registers as they were
        write_reg(REG_VD_LO, ~last_vd.w[0], 1'b1);
        write_reg(REG_VD_HI, ~last_vd.w[1], 1'b1);
        write_reg(REG_STATUS, 32'd0, 1'b1);
        write_reg(8'h28, 32'd1, 1'b1);
        read_reg(8'hFC, rd, 1'b1);
        read_reg(REG_VD_LO, b.w[0], 1'b0);
        read_reg(REG_VD_HI, b.w[1], 1'b0);
        check_vd("vd", b, last_vd);
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status.done", rd[0], 1'b1);

        // Done is low right after a CTRL write and high three cycles later
        write_reg(REG_CTRL, {26'd0, SEW_64, 1'b0, VAADD}, 1'b0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status.done", rd[0], 1'b0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status.done", rd[0], 1'b1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
